//--- hw/mem_pkg.sv
// pipeline memory access types
package mem_pkg;

  // data path and memory geometry
  localparam int XLEN        = 64;
  localparam int MEM_WORDS   = 256; // depth in XLEN words
  localparam int MEM_LATENCY = 2;   // slave cycles from accept to response

  // access width, also fixes the natural alignment
  typedef enum logic [1:0] {
    SIZE_B = 2'd0, // 1 byte
    SIZE_H = 2'd1, // 2 bytes
    SIZE_W = 2'd2, // 4 bytes
    SIZE_D = 2'd3  // 8 bytes
  } access_size_e;

  // one request from the pipeline
  // load and store are strobes, at most one is set
  typedef struct packed {
    logic              load;
    logic              store;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   wdata;
    access_size_e      size;
    logic              sext;  // sign extend load data
  } mem_req_t;

endpackage

//--- hw/bus_pkg.sv
// bus channel payload types
package bus_pkg;

  // byte offset bits inside one word
  localparam int ADDR_LSB = 3;

  // one strobe bit per byte lane
  localparam int STRB_W = mem_pkg::XLEN / 8;

  // write request channel payload
  typedef struct packed {
    logic [mem_pkg::XLEN-1:0] addr;
    logic [mem_pkg::XLEN-1:0] data; // already on its byte lanes
    logic [STRB_W-1:0]        strb;
  } bus_wreq_t;

  // read request channel payload, whole word comes back
  typedef struct packed {
    logic [mem_pkg::XLEN-1:0] addr;
  } bus_rreq_t;

endpackage

//--- hw/mem_lane_align.sv
// byte lane alignment
module mem_lane_align (
  input  logic [mem_pkg::XLEN-1:0]   wdata_i,
  input  logic [bus_pkg::ADDR_LSB-1:0] addr_off_i,
  input  mem_pkg::access_size_e      size_i,
  input  logic                       sext_i,
  input  logic [mem_pkg::XLEN-1:0]   rdata_i,
  output logic [mem_pkg::XLEN-1:0]   wdata_o,
  output logic [bus_pkg::STRB_W-1:0] strb_o,
  output logic [mem_pkg::XLEN-1:0]   load_data_o
);

  logic [bus_pkg::STRB_W-1:0] size_mask;
  logic [mem_pkg::XLEN-1:0]   rshift;
  logic [5:0]                 bit_off;

  assign bit_off = {addr_off_i, 3'b000}; // bytes to bits

  // size-many ones, low aligned
  always_comb begin
    case (size_i)
      mem_pkg::SIZE_B: size_mask = 8'h01;
      mem_pkg::SIZE_H: size_mask = 8'h03;
      mem_pkg::SIZE_W: size_mask = 8'h0f;
      default:         size_mask = 8'hff;
    endcase
  end

  // store path
  assign wdata_o = wdata_i << bit_off;
  assign strb_o  = size_mask << addr_off_i;

  // load path, addressed bytes down to lane 0
  assign rshift = rdata_i >> bit_off;

  always_comb begin
    case (size_i)
      mem_pkg::SIZE_B:
        load_data_o = {{(mem_pkg::XLEN-8){sext_i & rshift[7]}}, rshift[7:0]};
      mem_pkg::SIZE_H:
        load_data_o = {{(mem_pkg::XLEN-16){sext_i & rshift[15]}}, rshift[15:0]};
      mem_pkg::SIZE_W:
        load_data_o = {{(mem_pkg::XLEN-32){sext_i & rshift[31]}}, rshift[31:0]};
      default:
        load_data_o = rshift; // full word, nothing to extend
    endcase
  end

endmodule

//--- hw/bus_req_slot.sv
// single entry bus request holder
module bus_req_slot #(
  parameter type payload_t = logic [63:0]
) (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     load_i,
  input  payload_t payload_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t payload_o
);

  // valid stays up until the slave takes it
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else if (load_i) begin
      valid_o <= 1'b1;
    end else if (valid_o && ready_i) begin
      valid_o <= 1'b0; // transfer done
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      payload_o <= payload_i;
    end
  end

  // payload must not move under a stalled handshake
  a_payload_stable: assert property (
    @(posedge clk) disable iff (reset_i)
    valid_o && !ready_i |=> $stable(payload_o)
  ) else $error("bus_req_slot: payload changed while waiting for ready");

  // the sequencer may only refill an empty slot
  a_no_overwrite: assert property (
    @(posedge clk) disable iff (reset_i)
    valid_o |-> !load_i
  ) else $error("bus_req_slot: load while request still pending");

endmodule

//--- hw/mem_access_unit.sv
// load and store access sequencer
module mem_access_unit (
  input  logic                     clk,
  input  logic                     reset_i,
  input  mem_pkg::mem_req_t        req_i,
  output logic                     stall_o,
  output logic                     done_o,
  output logic [mem_pkg::XLEN-1:0] load_data_o,
  output logic                     wreq_valid_o,
  input  logic                     wreq_ready_i,
  output bus_pkg::bus_wreq_t       wreq_o,
  input  logic                     wresp_valid_i,
  output logic                     wresp_ready_o,
  output logic                     rreq_valid_o,
  input  logic                     rreq_ready_i,
  output bus_pkg::bus_rreq_t       rreq_o,
  input  logic                     rresp_valid_i,
  output logic                     rresp_ready_o,
  input  logic [mem_pkg::XLEN-1:0] rresp_data_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RESP, ST_DONE} state_e;

  state_e state_q;

  logic accept;
  logic req_xfer;
  logic resp_xfer;
  logic misalign;
  logic is_load_q;
  logic sext_q;
  logic [bus_pkg::ADDR_LSB-1:0] off_q;
  mem_pkg::access_size_e        size_q;

  logic [bus_pkg::ADDR_LSB-1:0] off_sel;
  mem_pkg::access_size_e        size_sel;
  logic                         sext_sel;
  logic [mem_pkg::XLEN-1:0]     wdata_al;
  logic [bus_pkg::STRB_W-1:0]   strb_al;
  logic [mem_pkg::XLEN-1:0]     load_al;
  bus_pkg::bus_wreq_t           wreq_new;
  bus_pkg::bus_rreq_t           rreq_new;

  assign stall_o = (state_q == ST_REQ) || (state_q == ST_RESP);
  assign done_o  = (state_q == ST_DONE);
  assign accept  = !stall_o && (req_i.load || req_i.store); // done cycle can take the next one

  assign req_xfer  = is_load_q ? (rreq_valid_o && rreq_ready_i)
                               : (wreq_valid_o && wreq_ready_i);
  assign resp_xfer = is_load_q ? (rresp_valid_i && rresp_ready_o)
                               : (wresp_valid_i && wresp_ready_o);

  assign wresp_ready_o = (state_q == ST_RESP) && !is_load_q;
  assign rresp_ready_o = (state_q == ST_RESP) && is_load_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_REQ:  if (req_xfer) state_q <= ST_RESP;
        ST_RESP: if (resp_xfer) state_q <= ST_DONE;
        default: state_q <= accept ? ST_REQ : ST_IDLE;
      endcase
    end
  end

  // access shape kept for the load return path
  always_ff @(posedge clk) begin
    if (accept) begin
      is_load_q <= req_i.load;
      off_q     <= req_i.addr[bus_pkg::ADDR_LSB-1:0];
      size_q    <= req_i.size;
      sext_q    <= req_i.sext;
    end
    if (rresp_valid_i && rresp_ready_o) begin
      load_data_o <= load_al;
    end
  end

  // live request while idle, latched copy while busy
  assign off_sel  = stall_o ? off_q : req_i.addr[bus_pkg::ADDR_LSB-1:0];
  assign size_sel = stall_o ? size_q : req_i.size;
  assign sext_sel = stall_o ? sext_q : req_i.sext;

  mem_lane_align u_align (
    .wdata_i     (req_i.wdata),
    .addr_off_i  (off_sel),
    .size_i      (size_sel),
    .sext_i      (sext_sel),
    .rdata_i     (rresp_data_i),
    .wdata_o     (wdata_al),
    .strb_o      (strb_al),
    .load_data_o (load_al)
  );

  always_comb begin
    wreq_new.addr = req_i.addr;
    wreq_new.data = wdata_al;
    wreq_new.strb = strb_al;
    rreq_new.addr = req_i.addr;
  end

  bus_req_slot #(.payload_t(bus_pkg::bus_wreq_t)) u_wslot (
    .clk       (clk),
    .reset_i   (reset_i),
    .load_i    (accept && req_i.store),
    .payload_i (wreq_new),
    .valid_o   (wreq_valid_o),
    .ready_i   (wreq_ready_i),
    .payload_o (wreq_o)
  );

  bus_req_slot #(.payload_t(bus_pkg::bus_rreq_t)) u_rslot (
    .clk       (clk),
    .reset_i   (reset_i),
    .load_i    (accept && req_i.load),
    .payload_i (rreq_new),
    .valid_o   (rreq_valid_o),
    .ready_i   (rreq_ready_i),
    .payload_o (rreq_o)
  );

  // low address bits that must be zero for this size
  always_comb begin
    case (req_i.size)
      mem_pkg::SIZE_B: misalign = 1'b0;
      mem_pkg::SIZE_H: misalign = req_i.addr[0];
      mem_pkg::SIZE_W: misalign = |req_i.addr[1:0];
      default:         misalign = |req_i.addr[2:0];
    endcase
  end

  a_aligned: assert property (
    @(posedge clk) disable iff (reset_i)
    accept |-> !misalign
  ) else $error("mem_access_unit: misaligned access accepted");

  a_one_kind: assert property (
    @(posedge clk) disable iff (reset_i)
    !(req_i.load && req_i.store)
  ) else $error("mem_access_unit: load and store set together");

endmodule

//--- hw/sram_bus_slave.sv
// word wide sram bus slave
module sram_bus_slave #(
  parameter int LATENCY = 1
) (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     wreq_valid_i,
  output logic                     wreq_ready_o,
  input  bus_pkg::bus_wreq_t       wreq_i,
  output logic                     wresp_valid_o,
  input  logic                     wresp_ready_i,
  input  logic                     rreq_valid_i,
  output logic                     rreq_ready_o,
  input  bus_pkg::bus_rreq_t       rreq_i,
  output logic                     rresp_valid_o,
  input  logic                     rresp_ready_i,
  output logic [mem_pkg::XLEN-1:0] rresp_data_o
);

  localparam int IDX_W = $clog2(mem_pkg::MEM_WORDS);
  localparam int CNT_W = $clog2(LATENCY + 1);

  logic [mem_pkg::XLEN-1:0] mem [mem_pkg::MEM_WORDS];

  logic             busy_q;
  logic             resp_q;    // response pending on its channel
  logic             is_read_q;
  logic [CNT_W-1:0] cnt_q;

  logic             rd_acc;
  logic             wr_acc;
  logic             resp_xfer;
  logic [IDX_W-1:0] widx;
  logic [IDX_W-1:0] ridx;

  // read wins when both channels ask in the same cycle
  assign rreq_ready_o = !busy_q && rreq_valid_i;
  assign wreq_ready_o = !busy_q && wreq_valid_i && !rreq_valid_i;

  assign rd_acc = rreq_valid_i && rreq_ready_o;
  assign wr_acc = wreq_valid_i && wreq_ready_o;

  assign wresp_valid_o = resp_q && !is_read_q;
  assign rresp_valid_o = resp_q && is_read_q;
  assign resp_xfer     = (wresp_valid_o && wresp_ready_i) ||
                         (rresp_valid_o && rresp_ready_i);

  assign widx = wreq_i.addr[bus_pkg::ADDR_LSB +: IDX_W];
  assign ridx = rreq_i.addr[bus_pkg::ADDR_LSB +: IDX_W];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      resp_q <= 1'b0;
      cnt_q  <= '0;
    end else if (rd_acc || wr_acc) begin
      busy_q <= 1'b1;
      resp_q <= (LATENCY == 1);
      cnt_q  <= CNT_W'(LATENCY - 1);
    end else if (busy_q && !resp_q) begin
      cnt_q <= cnt_q - 1'b1; // countdown to response
      if (cnt_q == CNT_W'(1)) begin
        resp_q <= 1'b1;
      end
    end else if (resp_xfer) begin
      resp_q <= 1'b0;
      busy_q <= 1'b0;
    end
  end

  // array access happens at accept and the response only waits
  always_ff @(posedge clk) begin
    if (rd_acc || wr_acc) begin
      is_read_q <= rd_acc;
    end
    if (rd_acc) begin
      rresp_data_o <= mem[ridx];
    end
    if (wr_acc) begin
      for (int b = 0; b < bus_pkg::STRB_W; b++) begin
        if (wreq_i.strb[b]) begin
          mem[widx][b*8 +: 8] <= wreq_i.data[b*8 +: 8];
        end
      end
    end
  end

  // a write that lost to a read must wait unchanged
  a_wreq_hold: assert property (
    @(posedge clk) disable iff (reset_i)
    wreq_valid_i && !wreq_ready_o |=> wreq_valid_i && $stable(wreq_i)
  ) else $error("sram_bus_slave: write request changed before it was accepted");

endmodule

//--- hw/mem_stage_top.sv
// data memory stage with sram slave
module mem_stage_top (
  input  logic                     clk,
  input  logic                     reset_i,
  input  mem_pkg::mem_req_t        req_i,
  output logic                     stall_o,
  output logic                     done_o,
  output logic [mem_pkg::XLEN-1:0] load_data_o
);

  logic                     wreq_valid;
  logic                     wreq_ready;
  bus_pkg::bus_wreq_t       wreq;
  logic                     wresp_valid;
  logic                     wresp_ready;
  logic                     rreq_valid;
  logic                     rreq_ready;
  bus_pkg::bus_rreq_t       rreq;
  logic                     rresp_valid;
  logic                     rresp_ready;
  logic [mem_pkg::XLEN-1:0] rresp_data;

  mem_access_unit u_access (
    .clk           (clk),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .stall_o       (stall_o),
    .done_o        (done_o),
    .load_data_o   (load_data_o),
    .wreq_valid_o  (wreq_valid),
    .wreq_ready_i  (wreq_ready),
    .wreq_o        (wreq),
    .wresp_valid_i (wresp_valid),
    .wresp_ready_o (wresp_ready),
    .rreq_valid_o  (rreq_valid),
    .rreq_ready_i  (rreq_ready),
    .rreq_o        (rreq),
    .rresp_valid_i (rresp_valid),
    .rresp_ready_o (rresp_ready),
    .rresp_data_i  (rresp_data)
  );

  sram_bus_slave #(.LATENCY(mem_pkg::MEM_LATENCY)) u_sram (
    .clk           (clk),
    .reset_i       (reset_i),
    .wreq_valid_i  (wreq_valid),
    .wreq_ready_o  (wreq_ready),
    .wreq_i        (wreq),
    .wresp_valid_o (wresp_valid),
    .wresp_ready_i (wresp_ready),
    .rreq_valid_i  (rreq_valid),
    .rreq_ready_o  (rreq_ready),
    .rreq_i        (rreq),
    .rresp_valid_o (rresp_valid),
    .rresp_ready_i (rresp_ready),
    .rresp_data_o  (rresp_data)
  );

endmodule

//--- test/tb_mem_stage_vectors.svh
// memory stage stimulus table
localparam logic [1:0] K_STORE = 2'd0;
localparam logic [1:0] K_LOAD  = 2'd1;
localparam logic [1:0] K_BLOCK = 2'd2; // store, then a second strobe while stalled

typedef struct packed {
  logic [1:0]            kind;
  logic [63:0]           addr;
  logic [63:0]           data;
  mem_pkg::access_size_e size;
  logic                  sext;
  logic [63:0]           exp_val; // load result, don't care for stores
} vec_t;

vec_t vec_q[$];

task automatic push_entry(input logic [1:0] kind, input logic [63:0] addr,
                          input logic [63:0] data, input mem_pkg::access_size_e size,
                          input logic sext, input logic [63:0] exp_val);
  vec_q.push_back({kind, addr, data, size, sext, exp_val});
endtask

task automatic fill_vector_table();
  logic [63:0] word;
  logic [63:0] mask;
  logic [63:0] val;
  logic [63:0] base;
  logic [63:0] rnd [8];
  push_entry(K_STORE, 64'h08, 64'hdead_beef_0bad_f00d, mem_pkg::SIZE_D, 1'b0, '0);
  push_entry(K_LOAD, 64'h08, '0, mem_pkg::SIZE_D, 1'b0, 64'hdead_beef_0bad_f00d);
  // byte, half and word at each aligned offset, reloaded as a doubleword
  for (int s = 0; s < 3; s++) begin
    base = 64'h18 + 64'(8 * s);
    word = 64'h0123_4567_89ab_cdef;
    mask = (64'd1 << (8 << s)) - 64'd1;
    push_entry(K_STORE, base, word, mem_pkg::SIZE_D, 1'b0, '0);
    for (int off = 0; off < 8; off += (1 << s)) begin
      val  = 64'hf7e6_d5c4_b3a2_9180 + 64'(off); // upper bytes must not land
      word = (word & ~(mask << (8 * off))) | ((val & mask) << (8 * off));
      push_entry(K_STORE, base + 64'(off), val, mem_pkg::access_size_e'(s), 1'b0, '0);
      push_entry(K_LOAD, base, '0, mem_pkg::SIZE_D, 1'b0, word);
    end
  end
  // every width with its top bit set, signed and unsigned
  push_entry(K_STORE, 64'h40, 64'h8123_4567_89ab_cdef, mem_pkg::SIZE_D, 1'b0, '0);
  push_entry(K_LOAD, 64'h40, '0, mem_pkg::SIZE_B, 1'b1, 64'hffff_ffff_ffff_ffef);
  push_entry(K_LOAD, 64'h40, '0, mem_pkg::SIZE_B, 1'b0, 64'h0000_0000_0000_00ef);
  push_entry(K_LOAD, 64'h43, '0, mem_pkg::SIZE_B, 1'b1, 64'hffff_ffff_ffff_ff89);
  push_entry(K_LOAD, 64'h46, '0, mem_pkg::SIZE_H, 1'b1, 64'hffff_ffff_ffff_8123);
  push_entry(K_LOAD, 64'h46, '0, mem_pkg::SIZE_H, 1'b0, 64'h0000_0000_0000_8123);
  push_entry(K_LOAD, 64'h42, '0, mem_pkg::SIZE_H, 1'b1, 64'hffff_ffff_ffff_89ab);
  push_entry(K_LOAD, 64'h44, '0, mem_pkg::SIZE_W, 1'b1, 64'hffff_ffff_8123_4567);
  push_entry(K_LOAD, 64'h44, '0, mem_pkg::SIZE_W, 1'b0, 64'h0000_0000_8123_4567);
  push_entry(K_LOAD, 64'h40, '0, mem_pkg::SIZE_W, 1'b1, 64'hffff_ffff_89ab_cdef);
  push_entry(K_LOAD, 64'h40, '0, mem_pkg::SIZE_D, 1'b1, 64'h8123_4567_89ab_cdef);
  // strobe during stall must be ignored
  push_entry(K_BLOCK, 64'h30, 64'h5a5a_0f0f_a5a5_f0f0, mem_pkg::SIZE_D, 1'b0, '0);
  push_entry(K_LOAD, 64'h30, '0, mem_pkg::SIZE_D, 1'b0, 64'h5a5a_0f0f_a5a5_f0f0);
  // random doublewords
  for (int i = 0; i < 8; i++) begin
    rnd[i] = {$random(seed), $random(seed)};
    push_entry(K_STORE, 64'(8 * (64 + 3 * i)), rnd[i], mem_pkg::SIZE_D, 1'b0, '0);
  end
  for (int i = 0; i < 8; i++) begin
    push_entry(K_LOAD, 64'(8 * (64 + 3 * i)), '0, mem_pkg::SIZE_D, 1'b0, rnd[i]);
  end
endtask

//--- test/tb_mem_stage.sv
// memory stage testbench
module tb_mem_stage;

  localparam int CYCLE     = 100;
  localparam int DRIVE_DLY = 10;
  localparam int MAX_WAIT  = 20; // cycles allowed per access
  localparam int MODEL_SZ  = mem_pkg::MEM_WORDS * 8;

  logic                     clk;
  logic                     reset_i;
  mem_pkg::mem_req_t        req;
  logic                     stall;
  logic                     done;
  logic [mem_pkg::XLEN-1:0] load_data;

  integer     seed;
  int         errors   = 0;
  int         done_cnt = 0;
  int         n_pass   = 0;
  int         n_fail   = 0;
  logic [7:0] shadow [MODEL_SZ]; // byte image of the sram

  `include "tb_mem_stage_vectors.svh"

  mem_stage_top u_dut (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_i       (req),
    .stall_o     (stall),
    .done_o      (done),
    .load_data_o (load_data)
  );

  initial clk = 1'b0;
  always #(CYCLE / 2) clk = ~clk;

  always @(negedge clk) begin
    if (!reset_i && done) begin
      done_cnt++;
    end
  end

  task automatic report_error(input string tag, input string msg);
    $display("%s at %0t: %s", tag, $time, msg);
    errors++;
  endtask

  task automatic model_write(input logic [63:0] addr, input logic [63:0] data,
                             input mem_pkg::access_size_e size);
    for (int b = 0; b < (1 << int'(size)); b++) begin
      shadow[(addr + b) % MODEL_SZ] = data[b*8 +: 8];
    end
  endtask

  function automatic logic [63:0] model_read(input logic [63:0] addr,
                                             input mem_pkg::access_size_e size,
                                             input logic sext);
    logic [63:0] val;
    int          n;
    n   = 1 << int'(size);
    val = '0;
    for (int b = 0; b < n; b++) begin
      val[b*8 +: 8] = shadow[(addr + b) % MODEL_SZ];
    end
    if (sext && val[n*8-1]) begin
      val = val | ~((64'd1 << (n * 8)) - 64'd1); // no-op for doublewords
    end
    return val;
  endfunction

  task automatic run_entry(input int idx, input vec_t v);
    logic [63:0] model_val;
    int          cnt_before;
    int          err_before;
    int          wait_cnt;
    err_before = errors;
    cnt_before = done_cnt;
    @(posedge clk);
    #DRIVE_DLY;
    while (stall) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
    req       = '0;
    req.load  = (v.kind == K_LOAD);
    req.store = (v.kind != K_LOAD);
    req.addr  = v.addr;
    req.wdata = v.data;
    req.size  = v.size;
    req.sext  = v.sext;
    @(posedge clk);
    #DRIVE_DLY;
    req = '0;
    if (v.kind == K_BLOCK) begin
      assert (stall) else report_error("error", "stall_o low right after an accepted request");
      req.store = 1'b1; // same address, inverted data
      req.addr  = v.addr;
      req.wdata = ~v.data;
      req.size  = v.size;
      @(posedge clk);
      #DRIVE_DLY;
      req = '0;
    end
    wait_cnt = 0;
    @(negedge clk);
    while (!done && wait_cnt < MAX_WAIT) begin
      assert (stall) else report_error("error", $sformatf("stall_o low in flight, test %0d", idx));
      wait_cnt++;
      @(negedge clk);
    end
    assert (done) else report_error("error", $sformatf("done_o never came for test %0d", idx));
    assert (!stall) else report_error("error", "stall_o still high together with done_o");
    if (v.kind == K_LOAD) begin
      model_val = model_read(v.addr, v.size, v.sext);
      assert (model_val === v.exp_val) else report_error("mismatch",
        $sformatf("test %0d memory model gives %h, table expects %h", idx, model_val, v.exp_val));
      assert (load_data === v.exp_val) else report_error("mismatch",
        $sformatf("test %0d load 0x%0h got %h expected %h", idx, v.addr, load_data, v.exp_val));
    end else begin
      model_write(v.addr, v.data, v.size);
    end
    @(posedge clk);
    assert (done_cnt == cnt_before + 1) else report_error("error",
      $sformatf("test %0d saw %0d done_o pulses instead of one", idx, done_cnt - cnt_before));
    if (errors == err_before) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("test %0d %s addr 0x%0h size %0d: %s", idx, (v.kind == K_LOAD) ? "load " : "store",
             v.addr, int'(v.size), (errors == err_before) ? "ok" : "FAILED");
  endtask

  initial begin
    seed    = 26;
    reset_i = 1'b1;
    req     = '0;
    fill_vector_table();
    repeat (16) @(posedge clk);
    #DRIVE_DLY;
    reset_i = 1'b0;
    @(negedge clk);
    assert (!stall && !done) else report_error("error", "stall_o or done_o high after reset");
    for (int i = 0; i < vec_q.size(); i++) begin
      run_entry(i, vec_q[i]);
    end
    repeat (MAX_WAIT) @(posedge clk); // a late done_o would land here
    assert (done_cnt == vec_q.size()) else report_error("error",
      $sformatf("%0d done_o pulses for %0d requests", done_cnt, vec_q.size()));
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             vec_q.size(), n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog, budget scales with the table
  initial begin
    #1;
    #((vec_q.size() * MAX_WAIT + 2 * MAX_WAIT + 16) * CYCLE);
    $display("error at %0t: watchdog expired before the run finished", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- mem_stage_top.f
+incdir+test
hw/mem_pkg.sv
hw/bus_pkg.sv
hw/mem_lane_align.sv
hw/bus_req_slot.sv
hw/mem_access_unit.sv
hw/sram_bus_slave.sv
hw/mem_stage_top.sv
test/tb_mem_stage.sv
